// ==== list.f ====
common/decode_pkg.sv
rtl/sync_fifo.sv
decode/uop_crack.sv
decode/uop_pack.sv
decode/decode_ctrl.sv
rtl/decode_top.sv
sim/tb_decode_asserts.sv
sim/tb_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_decode
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
    localparam int NUM_GROUPS = 400;
    localparam int CYCLE_LIMIT = NUM_GROUPS * 8 + 200;

    logic clk_in;
    logic arst_n;
    logic flush;
    logic fetch_valid;
    logic [decode_pkg::INSN_WIDTH-1:0] fetch_ops [decode_pkg::SLOTS];
    logic [decode_pkg::PC_WIDTH-1:0] fetch_pc;
    logic decode_ready;
    logic exe_ready;
    logic uop_valid;
    decode_pkg::uop_t uop_lanes [decode_pkg::LANES];
    decode_pkg::count_t uop_count;

    decode_pkg::uop_bundle_t exp_q [$];
    int errors = 0;
    int checked = 0;
    int sent = 0;
    int cycles = 0;
    int tests = 0;
    int seg_groups = 0;
    int seg_bundles = 0;
    int seg_errors = 0;
    bit model_halt = 0;

    decode_top uut (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic decode_pkg::uop_t new_uop(input decode_pkg::uopcode_e code,
                                                 input decode_pkg::pc_t pc);
        decode_pkg::uop_t u;
        u = '0;
        u.uopcode = code;
        u.pc = pc;
        u.tx_begin = 1'b1;
        u.tx_end = 1'b1;
        u.mem_read = (code == decode_pkg::UOP_LOAD);
        u.mem_write = (code == decode_pkg::UOP_STORE);
        u.w_enable = !(code inside {decode_pkg::UOP_STORE, decode_pkg::UOP_HLT});
        return u;
    endfunction

    function automatic void append(inout decode_pkg::uop_bundle_t b, input decode_pkg::uop_t u);
        b.lanes[b.count] = u;
        b.count = decode_pkg::count_t'(b.count + 1);
    endfunction

    // expected micro-ops of one slot, returns 1 when the slot ends the group
    function automatic bit crack_slot(inout decode_pkg::uop_bundle_t b, input logic [31:0] w,
                                      input decode_pkg::pc_t pc);
        decode_pkg::uop_t u;
        decode_pkg::uopcode_e mem_code;
        mem_code = (w[31:21] == decode_pkg::OPC_LDUR) ? decode_pkg::UOP_LOAD
                                                       : decode_pkg::UOP_STORE;
        if (w[31:23] == decode_pkg::OPC_MOVZ || w[31:23] == decode_pkg::OPC_MOVK) begin
            u = new_uop((w[31:23] == decode_pkg::OPC_MOVZ) ? decode_pkg::UOP_MOVZ
                                                           : decode_pkg::UOP_MOVK, pc);
            u.dst = w[4:0];
            u.imm = decode_pkg::imm_t'(w[20:5]);
            u.hw = w[22:21];
            append(b, u);
        end else if (w[31:21] == decode_pkg::OPC_ADD_I || w[31:21] == decode_pkg::OPC_SUB_I) begin
            u = new_uop((w[31:21] == decode_pkg::OPC_ADD_I) ? decode_pkg::UOP_ADD
                                                            : decode_pkg::UOP_SUB, pc);
            u.dst = w[4:0];
            u.src1 = w[9:5];
            u.imm = decode_pkg::imm_t'(w[21:10]);
            append(b, u);
        end else if (w[31:21] inside {decode_pkg::OPC_ADDS_R, decode_pkg::OPC_SUBS_R,
                     decode_pkg::OPC_ORR_R, decode_pkg::OPC_EOR_R, decode_pkg::OPC_ANDS_R}) begin
            case (w[31:21])
                decode_pkg::OPC_ADDS_R: u = new_uop(decode_pkg::UOP_ADD, pc);
                decode_pkg::OPC_SUBS_R: u = new_uop(decode_pkg::UOP_SUB, pc);
                decode_pkg::OPC_ORR_R: u = new_uop(decode_pkg::UOP_ORR, pc);
                decode_pkg::OPC_EOR_R: u = new_uop(decode_pkg::UOP_EOR, pc);
                default: u = new_uop(decode_pkg::UOP_AND, pc);
            endcase
            u.dst = w[4:0];
            u.src1 = w[9:5];
            u.src2 = w[20:16];
            u.valb_sel = 1'b1;
            append(b, u);
        end else if (w[31:21] == decode_pkg::OPC_LDUR || w[31:21] == decode_pkg::OPC_STUR) begin
            if (w[20:12] != 9'd0) begin
                u = new_uop(decode_pkg::UOP_ADD, pc); // address into rt first
                u.dst = w[4:0];
                u.src1 = w[9:5];
                u.imm = decode_pkg::imm_t'(w[20:12]);
                u.tx_end = 1'b0;
                append(b, u);
                u = new_uop(mem_code, pc);
                u.dst = w[4:0];
                u.src1 = w[4:0];
                u.tx_begin = 1'b0;
                append(b, u);
            end else begin
                u = new_uop(mem_code, pc);
                u.dst = w[4:0];
                u.src1 = w[9:5];
                append(b, u);
            end
        end else if (w[31:21] == decode_pkg::OPC_B) begin
            return 1'b1;
        end else if (w[31:21] == decode_pkg::OPC_HLT) begin
            append(b, new_uop(decode_pkg::UOP_HLT, pc));
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic decode_pkg::uop_bundle_t model_group(input decode_pkg::pc_t pc,
                                                            input logic [31:0] w0,
                                                            input logic [31:0] w1);
        decode_pkg::uop_bundle_t b;
        b = '0;
        if (!crack_slot(b, w0, pc)) begin
            void'(crack_slot(b, w1, pc + 64'd4));
        end
        return b;
    endfunction

    function automatic bit holds_halt(input decode_pkg::uop_bundle_t b);
        for (int i = 0; i < decode_pkg::LANES; i++) begin
            if (b.lanes[i].uopcode == decode_pkg::UOP_HLT) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] rand_insn();
        logic [31:0] w;
        int k;
        w = $urandom;
        k = $urandom_range(0, 63);
        if (k == 0) begin
            w[31:21] = decode_pkg::OPC_HLT; // kept rare
            return w;
        end
        case (k % 14)
            0: w[31:21] = decode_pkg::OPC_ADD_I;
            1: w[31:21] = decode_pkg::OPC_SUB_I;
            2: w[31:21] = decode_pkg::OPC_ADDS_R;
            3: w[31:21] = decode_pkg::OPC_SUBS_R;
            4: w[31:21] = decode_pkg::OPC_ORR_R;
            5: w[31:21] = decode_pkg::OPC_EOR_R;
            6: w[31:21] = decode_pkg::OPC_ANDS_R;
            7: w[31:23] = decode_pkg::OPC_MOVZ;
            8: w[31:23] = decode_pkg::OPC_MOVK;
            9: w[31:21] = decode_pkg::OPC_LDUR;
            10: w[31:21] = decode_pkg::OPC_STUR;
            11: w[31:21] = decode_pkg::OPC_B;
            12: w[31:21] = decode_pkg::OPC_NOP;
            default: ; // unknown word
        endcase
        if ((k % 14) inside {9, 10} && $urandom_range(0, 2) == 0) w[20:12] = 9'd0;
        return w;
    endfunction

    task automatic compare_bundle(input decode_pkg::uop_bundle_t e);
        decode_pkg::uop_t g;
        decode_pkg::uop_t x;
        check("uop_count", 64'(uop_count), 64'(e.count));
        for (int i = 0; i < decode_pkg::LANES; i++) begin
            g = uop_lanes[i];
            x = e.lanes[i];
            check($sformatf("lane %0d uopcode", i), 64'(g.uopcode), 64'(x.uopcode));
            check($sformatf("lane %0d dst", i), 64'(g.dst), 64'(x.dst));
            check($sformatf("lane %0d src1", i), 64'(g.src1), 64'(x.src1));
            check($sformatf("lane %0d src2", i), 64'(g.src2), 64'(x.src2));
            check($sformatf("lane %0d imm", i), 64'(g.imm), 64'(x.imm));
            check($sformatf("lane %0d hw", i), 64'(g.hw), 64'(x.hw));
            check($sformatf("lane %0d valb_sel", i), 64'(g.valb_sel), 64'(x.valb_sel));
            check($sformatf("lane %0d mem_read", i), 64'(g.mem_read), 64'(x.mem_read));
            check($sformatf("lane %0d mem_write", i), 64'(g.mem_write), 64'(x.mem_write));
            check($sformatf("lane %0d w_enable", i), 64'(g.w_enable), 64'(x.w_enable));
            check($sformatf("lane %0d tx_begin", i), 64'(g.tx_begin), 64'(x.tx_begin));
            check($sformatf("lane %0d tx_end", i), 64'(g.tx_end), 64'(x.tx_end));
            check($sformatf("lane %0d pc", i), g.pc, x.pc);
        end
        checked++;
        seg_bundles++;
    endtask

    task automatic end_segment();
        tests++;
        $display("test %0d: %0d groups accepted, %0d bundles checked, %0d errors",
                 tests, seg_groups, seg_bundles, errors - seg_errors);
        seg_groups = 0;
        seg_bundles = 0;
        seg_errors = errors;
    endtask

    initial begin
        decode_pkg::uop_bundle_t b;
        int idle;
        bit done;
        bit hung;
        bit stall_prev;
        arst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_ops[0] = '0;
        fetch_ops[1] = '0;
        fetch_pc = '0;
        exe_ready = 1'b0;
        idle = 0;
        done = 0;
        hung = 0;
        stall_prev = 0;
        void'($urandom(18));
        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        arst_n = 1'b1;
        while (!done && !hung) begin
            @(negedge clk_in);
            cycles++;
            flush = 1'b0;
            if (model_halt && exp_q.size() == 0 && idle >= 6) begin
                flush = 1'b1; // leave the halt, queued groups are dropped
                fetch_valid = 1'b0;
                model_halt = 0;
                idle = 0;
                end_segment();
            end else begin
                if (model_halt && exp_q.size() == 0) idle++;
                fetch_valid = (sent < NUM_GROUPS) && ($urandom_range(0, 3) != 0);
                fetch_ops[0] = rand_insn();
                fetch_ops[1] = rand_insn();
                fetch_pc = {$urandom, $urandom} & ~64'h3;
            end
            exe_ready = ($urandom_range(0, 3) != 0);
            #1;
            // a full fetch queue needs a full bundle queue or a halt one cycle earlier
            if (!flush && !stall_prev) check("decode_ready", 64'(decode_ready), 64'd1);
            stall_prev = (exp_q.size() >= decode_pkg::BUNDLE_Q_DEPTH) || model_halt;
            if (fetch_valid && decode_ready) begin
                sent++;
                seg_groups++;
                if (!model_halt) begin
                    b = model_group(fetch_pc, fetch_ops[0], fetch_ops[1]);
                    if (b.count != '0) begin
                        exp_q.push_back(b);
                        if (holds_halt(b)) model_halt = 1;
                    end
                end
            end
            if (uop_valid && exe_ready) begin
                if (exp_q.size() == 0) begin
                    $display("error %0t: bundle transferred with none expected", $time);
                    errors++;
                end else begin
                    compare_bundle(exp_q.pop_front());
                end
            end
            if (cycles >= CYCLE_LIMIT) hung = 1;
            if (sent >= NUM_GROUPS && exp_q.size() == 0 && !uop_valid) done = 1;
        end
        end_segment();
        if (hung) $display("run hung with %0d bundles still expected", exp_q.size());
        $display("tests %0d, groups %0d, bundles %0d, errors %0d", tests, sent, checked, errors);
        if (errors == 0 && !hung) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_decode_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_asserts (
    input wire logic               clk_in,
    input wire logic               arst_n,
    input wire logic               flush,
    input wire logic               decode_ready,
    input wire logic               uop_valid,
    input wire decode_pkg::uop_t   uop_lanes [decode_pkg::LANES],
    input wire decode_pkg::count_t uop_count
);
    count_in_range: assert property (@(posedge clk_in) disable iff (!arst_n)
        uop_valid |-> uop_count <= decode_pkg::count_t'(decode_pkg::LANES))
        else $error("uop_count above lane count");

    idle_after_reset: assert property (@(posedge clk_in) $rose(arst_n) |-> !uop_valid)
        else $error("uop_valid high right after reset");

    flush_blocks_and_empties: assert property (@(posedge clk_in) disable iff (!arst_n)
        flush |-> !decode_ready ##1 !uop_valid)
        else $error("decode_ready high during flush or bundle left after flush");

    for (genvar i = 0; i < decode_pkg::LANES; i++) begin : g_lane
        unused_lane_nop: assert property (@(posedge clk_in) disable iff (!arst_n)
            (uop_valid && decode_pkg::count_t'(i) >= uop_count) |-> uop_lanes[i] == '0)
            else $error("lane %0d above uop_count is not a zero NOP", i);
    end

endmodule

bind decode_top tb_decode_asserts u_asserts (
    .clk_in (clk_in), .arst_n (arst_n), .flush (flush), .decode_ready (decode_ready),
    .uop_valid (uop_valid), .uop_lanes (uop_lanes), .uop_count (uop_count)
);

`default_nettype wire

// ==== rtl/decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int GROUP_Q_DEPTH  = decode_pkg::GROUP_Q_DEPTH,
    parameter int BUNDLE_Q_DEPTH = decode_pkg::BUNDLE_Q_DEPTH
) (
    input  logic                              clk_in,
    input  logic                              arst_n,
    input  logic                              flush,
    input  logic                              fetch_valid,
    input  logic [decode_pkg::INSN_WIDTH-1:0] fetch_ops [decode_pkg::SLOTS],
    input  logic [decode_pkg::PC_WIDTH-1:0]   fetch_pc,
    output logic                              decode_ready,
    input  logic                              exe_ready,
    output logic                              uop_valid,
    output decode_pkg::uop_t                  uop_lanes [decode_pkg::LANES],
    output decode_pkg::count_t                uop_count
);
    decode_pkg::fetch_group_t group_in;
    decode_pkg::fetch_group_t group_head;
    decode_pkg::uop_bundle_t  bundle_in;
    decode_pkg::uop_bundle_t  bundle_head;
    logic group_empty;
    logic group_full;
    logic group_pop;
    logic bundle_empty;
    logic bundle_full;
    logic bundle_push;
    logic queue_clear;
    logic has_halt;

    always_comb begin
        group_in.pc = fetch_pc;
        for (int i = 0; i < decode_pkg::SLOTS; i++) begin
            group_in.ops[i] = fetch_ops[i];
        end
    end

    assign decode_ready = !group_full && !flush;

    sync_fifo #(.T(decode_pkg::fetch_group_t), .DEPTH(GROUP_Q_DEPTH)) u_group_q (
        .clk_in (clk_in), .arst_n (arst_n), .clear (queue_clear),
        .push (fetch_valid && decode_ready), .data_in (group_in),
        .pop (group_pop), .head (group_head), .empty (group_empty), .full (group_full)
    );

    uop_pack u_pack (.group (group_head), .bundle (bundle_in), .has_halt (has_halt));

    decode_ctrl u_ctrl (
        .clk_in (clk_in), .arst_n (arst_n), .flush (flush),
        .group_empty (group_empty), .bundle_full (bundle_full),
        .bundle_count (bundle_in.count), .has_halt (has_halt),
        .group_pop (group_pop), .bundle_push (bundle_push), .queue_clear (queue_clear)
    );

    sync_fifo #(.T(decode_pkg::uop_bundle_t), .DEPTH(BUNDLE_Q_DEPTH)) u_bundle_q (
        .clk_in (clk_in), .arst_n (arst_n), .clear (queue_clear),
        .push (bundle_push), .data_in (bundle_in),
        .pop (uop_valid && exe_ready), .head (bundle_head),
        .empty (bundle_empty), .full (bundle_full)
    );

    assign uop_valid = !bundle_empty;
    assign uop_count = bundle_head.count;

    always_comb begin
        for (int i = 0; i < decode_pkg::LANES; i++) begin
            uop_lanes[i] = bundle_head.lanes[i];
        end
    end

endmodule

`default_nettype wire

// ==== decode/decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  logic               clk_in,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               group_empty,
    input  logic               bundle_full,
    input  decode_pkg::count_t bundle_count,
    input  logic               has_halt,
    output logic               group_pop,
    output logic               bundle_push,
    output logic               queue_clear
);
    logic halted;
    logic advance;

    // one group decoded per cycle when there is room downstream
    assign advance     = !flush && !group_empty && !halted && !bundle_full;
    assign group_pop   = advance;
    assign bundle_push = advance && (bundle_count != '0); // empty groups just retire
    assign queue_clear = flush;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (flush) begin
            halted <= 1'b0;
        end else if (bundle_push && has_halt) begin
            halted <= 1'b1; // held until the next flush
        end
    end

endmodule

`default_nettype wire

// ==== decode/uop_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_pack (
    input  decode_pkg::fetch_group_t group,
    output decode_pkg::uop_bundle_t  bundle,
    output logic                     has_halt
);
    decode_pkg::uop_t           slot_uops [decode_pkg::SLOTS][2];
    logic [1:0]                 slot_num  [decode_pkg::SLOTS];
    logic [decode_pkg::SLOTS-1:0] slot_ends;
    logic [decode_pkg::SLOTS-1:0] slot_halt;
    decode_pkg::count_t         lane_idx;
    logic                       stop;

    for (genvar s = 0; s < decode_pkg::SLOTS; s++) begin : g_slot
        uop_crack u_crack (
            .insn       (group.ops[s]),
            .pc         (group.pc + decode_pkg::pc_t'(4 * s)),
            .uops       (slot_uops[s]),
            .uop_num    (slot_num[s]),
            .ends_group (slot_ends[s]),
            .is_halt    (slot_halt[s])
        );
    end

    // slots in program order, lanes filled from 0 without gaps
    always_comb begin
        bundle   = '0;
        has_halt = 1'b0;
        lane_idx = '0;
        stop     = 1'b0;
        for (int s = 0; s < decode_pkg::SLOTS; s++) begin
            if (!stop) begin
                for (int k = 0; k < 2; k++) begin
                    if (k < int'(slot_num[s])) begin
                        bundle.lanes[lane_idx] = slot_uops[s][k];
                        lane_idx = lane_idx + decode_pkg::count_t'(1);
                    end
                end
                has_halt = has_halt | slot_halt[s];
                stop     = slot_ends[s]; // younger slots are dropped
            end
        end
        bundle.count = lane_idx;
    end

endmodule

`default_nettype wire

// ==== decode/uop_crack.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_crack (
    input  logic [decode_pkg::INSN_WIDTH-1:0] insn,
    input  logic [decode_pkg::PC_WIDTH-1:0]   pc,
    output decode_pkg::uop_t                  uops [2],
    output logic [1:0]                        uop_num,
    output logic                              ends_group,
    output logic                              is_halt
);
    logic [10:0] op11;
    logic [8:0]  op9;
    logic [8:0]  mem_off;
    logic        is_load;

    assign op11    = insn[31:21];
    assign op9     = insn[31:23];
    assign mem_off = insn[20:12];
    assign is_load = (op11 == decode_pkg::OPC_LDUR);

    // single-op defaults, format specific fields are filled by the caller
    function automatic decode_pkg::uop_t make_uop(input decode_pkg::uopcode_e code,
                                                  input decode_pkg::pc_t upc);
        decode_pkg::uop_t u;
        u           = '0;
        u.uopcode   = code;
        u.pc        = upc;
        u.tx_begin  = 1'b1;
        u.tx_end    = 1'b1;
        u.mem_read  = (code == decode_pkg::UOP_LOAD);
        u.mem_write = (code == decode_pkg::UOP_STORE);
        u.w_enable  = (code != decode_pkg::UOP_STORE) && (code != decode_pkg::UOP_HLT);
        return u;
    endfunction

    function automatic decode_pkg::uopcode_e rr_code(input logic [10:0] opc);
        case (opc)
            decode_pkg::OPC_SUBS_R: return decode_pkg::UOP_SUB;
            decode_pkg::OPC_ORR_R:  return decode_pkg::UOP_ORR;
            decode_pkg::OPC_EOR_R:  return decode_pkg::UOP_EOR;
            decode_pkg::OPC_ANDS_R: return decode_pkg::UOP_AND;
            default:                return decode_pkg::UOP_ADD;
        endcase
    endfunction

    always_comb begin
        uops[0]    = '0;
        uops[1]    = '0;
        uop_num    = 2'd0;
        ends_group = 1'b0;
        is_halt    = 1'b0;
        if (op9 == decode_pkg::OPC_MOVZ || op9 == decode_pkg::OPC_MOVK) begin
            uops[0] = make_uop((op9 == decode_pkg::OPC_MOVZ) ? decode_pkg::UOP_MOVZ
                                                             : decode_pkg::UOP_MOVK, pc);
            uops[0].dst = insn[4:0];
            uops[0].imm = decode_pkg::imm_t'(insn[20:5]);
            uops[0].hw  = insn[22:21];
            uop_num     = 2'd1;
        end else begin
            case (op11)
                decode_pkg::OPC_ADD_I, decode_pkg::OPC_SUB_I: begin
                    uops[0] = make_uop((op11 == decode_pkg::OPC_ADD_I) ? decode_pkg::UOP_ADD
                                                                       : decode_pkg::UOP_SUB, pc);
                    uops[0].dst  = insn[4:0];
                    uops[0].src1 = insn[9:5];
                    uops[0].imm  = decode_pkg::imm_t'(insn[21:10]);
                    uop_num      = 2'd1;
                end
                decode_pkg::OPC_ADDS_R, decode_pkg::OPC_SUBS_R, decode_pkg::OPC_ORR_R,
                decode_pkg::OPC_EOR_R, decode_pkg::OPC_ANDS_R: begin
                    uops[0]          = make_uop(rr_code(op11), pc);
                    uops[0].dst      = insn[4:0];
                    uops[0].src1     = insn[9:5];
                    uops[0].src2     = insn[20:16];
                    uops[0].valb_sel = 1'b1;
                    uop_num          = 2'd1;
                end
                decode_pkg::OPC_LDUR, decode_pkg::OPC_STUR: begin
                    if (mem_off != '0) begin
                        // address add lands in rt, the access then reuses rt as base
                        uops[0]        = make_uop(decode_pkg::UOP_ADD, pc);
                        uops[0].dst    = insn[4:0];
                        uops[0].src1   = insn[9:5];
                        uops[0].imm    = decode_pkg::imm_t'(mem_off);
                        uops[0].tx_end = 1'b0;
                        uops[1] = make_uop(is_load ? decode_pkg::UOP_LOAD
                                                   : decode_pkg::UOP_STORE, pc);
                        uops[1].dst      = insn[4:0];
                        uops[1].src1     = insn[4:0];
                        uops[1].tx_begin = 1'b0;
                        uop_num          = 2'd2;
                    end else begin
                        uops[0] = make_uop(is_load ? decode_pkg::UOP_LOAD
                                                   : decode_pkg::UOP_STORE, pc);
                        uops[0].dst  = insn[4:0];
                        uops[0].src1 = insn[9:5];
                        uop_num      = 2'd1;
                    end
                end
                decode_pkg::OPC_B: begin
                    ends_group = 1'b1; // resolved before decode
                end
                decode_pkg::OPC_HLT: begin
                    uops[0]    = make_uop(decode_pkg::UOP_HLT, pc);
                    uop_num    = 2'd1;
                    ends_group = 1'b1;
                    is_halt    = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 2
) (
    input  logic clk_in,
    input  logic arst_n,
    input  logic clear,
    input  logic push,
    input  T     data_in,
    input  logic pop,
    output T     head,
    output logic empty,
    output logic full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== common/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int INSN_WIDTH     = 32;
    localparam int SLOTS          = 2;
    localparam int LANES          = 4;  // two micro-ops per slot at most
    localparam int PC_WIDTH       = 64;
    localparam int REG_WIDTH      = 5;
    localparam int IMM_WIDTH      = 21;
    localparam int GROUP_Q_DEPTH  = 2;
    localparam int BUNDLE_Q_DEPTH = 2;
    localparam int CNT_WIDTH      = $clog2(LANES + 1);

    // major opcodes, matched against insn[31:21]
    localparam logic [10:0] OPC_ADD_I  = 11'b10010001000;
    localparam logic [10:0] OPC_SUB_I  = 11'b11010001000;
    localparam logic [10:0] OPC_ADDS_R = 11'b10101011000;
    localparam logic [10:0] OPC_SUBS_R = 11'b11101011000;
    localparam logic [10:0] OPC_ORR_R  = 11'b10101010000;
    localparam logic [10:0] OPC_EOR_R  = 11'b11001010000;
    localparam logic [10:0] OPC_ANDS_R = 11'b11101010000;
    localparam logic [10:0] OPC_LDUR   = 11'b11111000010;
    localparam logic [10:0] OPC_STUR   = 11'b11111000000;
    localparam logic [10:0] OPC_B      = 11'b00010100000;
    localparam logic [10:0] OPC_HLT    = 11'b11010100010;
    localparam logic [10:0] OPC_NOP    = 11'b11010101000;

    // wide-immediate moves, matched against insn[31:23]
    localparam logic [8:0] OPC_MOVZ = 9'b110100101;
    localparam logic [8:0] OPC_MOVK = 9'b111100101;

    typedef logic [INSN_WIDTH-1:0] insn_t;
    typedef logic [PC_WIDTH-1:0]   pc_t;
    typedef logic [REG_WIDTH-1:0]  reg_t;
    typedef logic [IMM_WIDTH-1:0]  imm_t;
    typedef logic [CNT_WIDTH-1:0]  count_t;

    typedef enum logic [3:0] {
        UOP_NOP   = 4'd0,
        UOP_ADD   = 4'd1,
        UOP_SUB   = 4'd2,
        UOP_ORR   = 4'd3,
        UOP_EOR   = 4'd4,
        UOP_AND   = 4'd5,
        UOP_MOVZ  = 4'd6,
        UOP_MOVK  = 4'd7,
        UOP_LOAD  = 4'd8,
        UOP_STORE = 4'd9,
        UOP_HLT   = 4'd10
    } uopcode_e;

    typedef struct packed {
        uopcode_e   uopcode;
        reg_t       dst;
        reg_t       src1;
        reg_t       src2;
        imm_t       imm;
        logic [1:0] hw;       // move halfword select
        logic       valb_sel; // operand b from src2, else imm
        logic       mem_read;
        logic       mem_write;
        logic       w_enable;
        logic       tx_begin;
        logic       tx_end;
        pc_t        pc;
    } uop_t;

    typedef struct packed {
        pc_t                   pc;
        insn_t [SLOTS-1:0]     ops;
    } fetch_group_t;

    typedef struct packed {
        uop_t [LANES-1:0] lanes;
        count_t           count;
    } uop_bundle_t;

endpackage

`default_nettype wire
